//--- hw/frv_pkg.sv
// ----------------------------
// Shared widths and encodings for the RV32 memory stage
// Micro-op layout follows the stage-3 decoder
// Trap causes are the 5-bit mcause codes
// ----------------------------
`default_nettype none

package frv_pkg;

    // ----------------------------
    // Widths
    // ----------------------------
    localparam int XLEN = 32;                  // Data and address width
    localparam int FU_W = 6;                   // Functional-unit one-hot
    localparam int OP_W = 7;                   // Micro-op width

    // Functional-unit one-hot bit positions
    localparam int P_FU_ALU = 0;
    localparam int P_FU_MUL = 1;
    localparam int P_FU_LSU = 2;
    localparam int P_FU_CFU = 3;
    localparam int P_FU_CSR = 4;
    localparam int P_FU_CRY = 5;

    // ----------------------------
    // LSU micro-op fields
    // ----------------------------
    localparam int LSU_SIGNED = 0;             // Sign-extend loaded data
    localparam int LSU_LOAD   = 3;             // Load
    localparam int LSU_STORE  = 4;             // Store

    // Width field, uop bits 2 to 1
    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    typedef enum logic [1:0] {
        WIDTH_NONE = 2'b00,                    // No access
        WIDTH_BYTE = LSU_BYTE,
        WIDTH_HALF = LSU_HALF,
        WIDTH_WORD = LSU_WORD
    } lsu_width_t;

    // Trap causes
    localparam logic [4:0] TRAP_LDALIGN = 5'd4; // Load address misaligned
    localparam logic [4:0] TRAP_STALIGN = 5'd6; // Store address misaligned

    // ----------------------------
    // Stage-4 payloads
    // ----------------------------
    typedef struct packed {
        logic [4:0]      rd;                   // Dest reg or trap cause
        logic [OP_W-1:0] uop;                  // Micro-op, zero for bubble
        logic [FU_W-1:0] fu;                   // Unit one-hot
        logic            trap;                 // Raise a trap
        logic [1:0]      size;                 // Instr size, zero for bubble
        logic [31:0]     instr;                // Instruction word
    } s4_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] opr_a;                // Strobes for LSU ops
        logic [XLEN-1:0] opr_b;                // Address for LSU ops
    } s4_opr_t;

endpackage

`default_nettype wire

//--- hw/frv_lsu_if.sv
// ----------------------------
// Access from the memory stage to the LSU
// Stage holds valid and all fields stable until ready
// ----------------------------
`default_nettype none

interface frv_lsu_if import frv_pkg::*; ();

    // Stage side
    logic            valid;                    // Access present, not done
    logic [XLEN-1:0] addr;                     // Byte address
    logic [XLEN-1:0] wdata;                    // Unaligned store data
    logic            load;
    logic            store;
    lsu_width_t      width;                    // Access width
    logic            is_signed;                // Kept for writeback

    // Unit side
    logic            ready;                    // Access finished
    logic            a_error;                  // Misaligned access
    logic [3:0]      strb;                     // Byte lanes

    modport stage (
        output valid, addr, wdata, load, store, width, is_signed,
        input  ready, a_error, strb
    );

    modport unit (
        input  valid, addr, wdata, load, store, width, is_signed,
        output ready, a_error, strb
    );

endinterface

`default_nettype wire

//--- hw/frv_lsu.sv
// ----------------------------
// Load/store unit, request side only
// Request is combinational from valid and held until grant
// Load data return lives in writeback
// ----------------------------
`default_nettype none

module frv_lsu import frv_pkg::*; (
    input  wire logic            g_clk,
    input  wire logic            g_resetn,
    input  wire logic            i_pipe_prog,     // Stage hands over its instr
    input  wire logic            i_hold_lsu_req,  // Delay new requests
    frv_lsu_if.unit              lsu,
    output logic                 o_dmem_req,
    output logic                 o_dmem_wen,
    output logic [3:0]           o_dmem_strb,
    output logic [XLEN-1:0]      o_dmem_wdata,
    output logic [XLEN-1:0]      o_dmem_addr,
    input  wire logic            i_dmem_gnt
);

    // ----------------------------
    // Alignment
    // ----------------------------
    logic half_mis;
    logic word_mis;

    assign half_mis = (lsu.width == WIDTH_HALF) && lsu.addr[0];
    assign word_mis = (lsu.width == WIDTH_WORD) && (lsu.addr[1:0] != 2'b00);

    assign lsu.a_error = lsu.valid && (half_mis || word_mis);

    // ----------------------------
    // Strobes and lane data
    // ----------------------------
    always_comb begin
        case (lsu.width)
            WIDTH_BYTE: lsu.strb = 4'b0001 << lsu.addr[1:0];
            WIDTH_HALF: lsu.strb = lsu.addr[1] ? 4'b1100 : 4'b0011;
            WIDTH_WORD: lsu.strb = 4'b1111;
            default:    lsu.strb = 4'b0000;       // No lanes
        endcase
    end

    always_comb begin
        case (lsu.width)
            WIDTH_BYTE: o_dmem_wdata = {4{lsu.wdata[7:0]}};   // Byte in every lane
            WIDTH_HALF: o_dmem_wdata = {2{lsu.wdata[15:0]}};  // Half in both halves
            default:    o_dmem_wdata = lsu.wdata;
        endcase
    end

    assign o_dmem_strb = lsu.strb;
    assign o_dmem_addr = {lsu.addr[XLEN-1:2], 2'b00};  // Word address
    assign o_dmem_wen  = lsu.store;

    // ----------------------------
    // Request control
    // ----------------------------
    logic done;       // Granted, instr still in stage
    logic req_pend;   // Raised last cycle, not granted

    // Hold only blocks a new request, never one already raised
    assign o_dmem_req = lsu.valid && !lsu.a_error && !done &&
                        (!i_hold_lsu_req || req_pend);

    assign lsu.ready  = lsu.a_error || done || (o_dmem_req && i_dmem_gnt);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done     <= 1'b0;
            req_pend <= 1'b0;
        end else begin
            req_pend <= o_dmem_req && !i_dmem_gnt;            // Still waiting
            if (i_pipe_prog) begin
                done <= 1'b0;                                 // Instr moved on
            end else if (o_dmem_req && i_dmem_gnt) begin
                done <= 1'b1;                                 // Stage 4 is busy
            end
        end
    end

    // ----------------------------
    // Checks
    // ----------------------------
    // Ungranted request stays up with the same address
    a_req_held: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (o_dmem_req && !i_dmem_gnt) |=> (o_dmem_req && $stable(o_dmem_addr))
    );

    // Misaligned access never reaches memory, not even a pending one
    a_no_req_on_error: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        lsu.a_error |-> (!o_dmem_req && !req_pend)
    );

endmodule

`default_nettype wire

//--- hw/frv_pipeline_register.sv
// ----------------------------
// Valid/busy pipeline register
// Loads when i_valid and stage N+1 not busy
// Flush and reset zero the payload too
// ----------------------------
`default_nettype none

module frv_pipeline_register #(
    parameter type T_PAYLOAD = logic [31:0]
) (
    input  wire logic      g_clk,
    input  wire logic      g_resetn,
    input  wire logic      i_flush,   // Kill held item
    input  wire logic      i_valid,   // Stage N offers data
    input  wire T_PAYLOAD  i_data,
    input  wire logic      i_busy,    // Stage N+1 refuses
    output T_PAYLOAD       o_data,
    output logic           o_valid,
    output logic           o_busy     // Push back to stage N
);

    // ----------------------------
    // Storage
    // ----------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else if (!i_busy) begin
            o_valid <= i_valid;                 // Drops if nothing offered
            if (i_valid) begin
                o_data <= i_data;
            end
        end
    end

    // Held item not taken yet
    assign o_busy = o_valid && i_busy;

    // ----------------------------
    // Checks
    // ----------------------------
    // Stage N+1 sees a steady payload while it stalls
    a_hold_stable: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (o_valid && i_busy && !i_flush) |=> $stable(o_data)
    );

endmodule

`default_nettype wire

//--- hw/frv_pipeline_memory.sv
// ----------------------------
// RV32 memory stage, stage 3 to stage 4
// Stage 3 presents size 0 for an empty slot
// i_s3_valid marks a new instruction
// Flush clears control only, operands stay
// ----------------------------
`default_nettype none

module frv_pipeline_memory import frv_pkg::*; (
    input  wire logic              g_clk,
    input  wire logic              g_resetn,
    input  wire logic              i_flush,
    input  wire logic              i_hold_lsu_req,
    input  wire logic [4:0]        i_s3_rd,
    input  wire logic [XLEN-1:0]   i_s3_opr_a,
    input  wire logic [XLEN-1:0]   i_s3_opr_b,
    input  wire logic [OP_W-1:0]   i_s3_uop,
    input  wire logic [FU_W-1:0]   i_s3_fu,
    input  wire logic              i_s3_trap,
    input  wire logic [1:0]        i_s3_size,
    input  wire logic [31:0]       i_s3_instr,
    input  wire logic              i_s3_valid,
    output logic                   o_s3_busy,
    output logic [4:0]             o_fwd_rd,
    output logic [XLEN-1:0]        o_fwd_wdata,
    output logic                   o_fwd_load,
    output logic                   o_fwd_csr,
    output logic                   o_dmem_req,
    output logic                   o_dmem_wen,
    output logic [3:0]             o_dmem_strb,
    output logic [XLEN-1:0]        o_dmem_wdata,
    output logic [XLEN-1:0]        o_dmem_addr,
    input  wire logic              i_dmem_gnt,
    output logic [4:0]             o_s4_rd,
    output logic [XLEN-1:0]        o_s4_opr_a,
    output logic [XLEN-1:0]        o_s4_opr_b,
    output logic [OP_W-1:0]        o_s4_uop,
    output logic [FU_W-1:0]        o_s4_fu,
    output logic                   o_s4_trap,
    output logic [1:0]             o_s4_size,
    output logic [31:0]            o_s4_instr,
    output logic                   o_s4_valid,
    input  wire logic              i_s4_busy
);

    frv_lsu_if lsu_bus ();

    // ----------------------------
    // Stall control
    // ----------------------------
    logic p_busy;                                  // Ctrl reg pushes back
    logic s3_full;
    logic instr_in;
    logic instr_out;
    logic pipe_prog_out;
    logic instr_done;                              // Slot already sent on
    logic lsu_valid;

    assign s3_full   = |i_s3_size;                 // Slot holds an instr
    assign o_s3_busy = p_busy || (lsu_valid && !lsu_bus.ready);

    assign instr_in      = i_s3_valid && !o_s3_busy;
    assign instr_out     = s3_full && !o_s3_busy && !instr_done;
    assign pipe_prog_out = !o_s3_busy;             // Instr or bubble moves

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            instr_done <= 1'b0;
        end else if (instr_in) begin
            instr_done <= 1'b0;                    // New instr in the slot
        end else if (instr_out) begin
            instr_done <= 1'b1;                    // Sent, slot now stale
        end
    end

    // ----------------------------
    // Decode
    // ----------------------------
    logic fu_lsu;
    logic fu_csr;

    assign fu_lsu    = i_s3_fu[P_FU_LSU];
    assign fu_csr    = i_s3_fu[P_FU_CSR];
    assign lsu_valid = fu_lsu && !instr_done;

    assign lsu_bus.valid     = lsu_valid;
    assign lsu_bus.addr      = i_s3_opr_a;         // Address from ALU
    assign lsu_bus.wdata     = i_s3_opr_b;         // rs2 for stores
    assign lsu_bus.load      = i_s3_uop[LSU_LOAD];
    assign lsu_bus.store     = i_s3_uop[LSU_STORE];
    assign lsu_bus.width     = lsu_width_t'(i_s3_uop[2:1]);
    assign lsu_bus.is_signed = i_s3_uop[LSU_SIGNED];

    // ----------------------------
    // Traps and next-stage values
    // ----------------------------
    logic       lsu_trap;
    logic [4:0] lsu_cause;
    s4_ctrl_t   n_ctrl;
    s4_opr_t    n_opr;
    s4_ctrl_t   s4_ctrl;
    s4_opr_t    s4_opr;

    assign lsu_trap  = fu_lsu && lsu_bus.a_error;
    assign lsu_cause = lsu_bus.load ? TRAP_LDALIGN : TRAP_STALIGN;

    always_comb begin
        n_ctrl.trap  = i_s3_trap || lsu_trap;
        n_ctrl.rd    = (lsu_trap && !i_s3_trap) ? lsu_cause : i_s3_rd;  // Older trap wins
        n_ctrl.uop   = instr_done ? '0 : i_s3_uop;   // Bubble when stale
        n_ctrl.fu    = instr_done ? '0 : i_s3_fu;
        n_ctrl.size  = instr_done ? 2'b00 : i_s3_size;
        n_ctrl.instr = i_s3_instr;
    end

    // LSU ops report strobes and address to writeback
    assign n_opr.opr_a = fu_lsu ? {{(XLEN-4){1'b0}}, lsu_bus.strb} : i_s3_opr_a;
    assign n_opr.opr_b = fu_lsu ? lsu_bus.addr : i_s3_opr_b;

    // ----------------------------
    // Forwarding
    // ----------------------------
    assign o_fwd_rd    = i_s3_rd;
    assign o_fwd_wdata = i_s3_opr_a;
    assign o_fwd_load  = fu_lsu && lsu_bus.load;
    assign o_fwd_csr   = fu_csr;

    // ----------------------------
    // Submodules
    // ----------------------------
    frv_lsu u_lsu (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .i_pipe_prog    (instr_in),
        .i_hold_lsu_req (i_hold_lsu_req),
        .lsu            (lsu_bus.unit),
        .o_dmem_req     (o_dmem_req),
        .o_dmem_wen     (o_dmem_wen),
        .o_dmem_strb    (o_dmem_strb),
        .o_dmem_wdata   (o_dmem_wdata),
        .o_dmem_addr    (o_dmem_addr),
        .i_dmem_gnt     (i_dmem_gnt)
    );

    frv_pipeline_register #(.T_PAYLOAD(s4_ctrl_t)) u_ctrl_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_valid  (pipe_prog_out),
        .i_data   (n_ctrl),
        .i_busy   (i_s4_busy),
        .o_data   (s4_ctrl),
        .o_valid  (o_s4_valid),
        .o_busy   (p_busy)
    );

    // Same load enable as control, so both stay in step
    frv_pipeline_register #(.T_PAYLOAD(s4_opr_t)) u_opr_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (1'b0),
        .i_valid  (pipe_prog_out),
        .i_data   (n_opr),
        .i_busy   (i_s4_busy),
        .o_data   (s4_opr),
        .o_valid  (),
        .o_busy   ()
    );

    assign o_s4_rd    = s4_ctrl.rd;
    assign o_s4_uop   = s4_ctrl.uop;
    assign o_s4_fu    = s4_ctrl.fu;
    assign o_s4_trap  = s4_ctrl.trap;
    assign o_s4_size  = s4_ctrl.size;
    assign o_s4_instr = s4_ctrl.instr;
    assign o_s4_opr_a = s4_opr.opr_a;
    assign o_s4_opr_b = s4_opr.opr_b;

    // ----------------------------
    // Checks
    // ----------------------------
    // Stage 3 stays stalled across every cycle of a pending request
    a_busy_while_waiting: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (o_dmem_req && !i_dmem_gnt) |-> o_s3_busy
    );

endmodule

`default_nettype wire

//--- dv/frv_mem_tb.sv
// ----------------------------
// Testbench for the RV32 memory stage
// Stage-3 slot is cleared right after each acceptance
// i_s4_busy only raised while stage 4 already holds an item
// ----------------------------
`default_nettype none

module frv_mem_tb import frv_pkg::*; ();

    localparam int N_INSTR = 37;                   // Instructions issued in total

    logic              g_clk;
    logic              g_resetn;
    logic              i_flush;
    logic              i_hold_lsu_req;
    logic [4:0]        i_s3_rd;
    logic [XLEN-1:0]   i_s3_opr_a;
    logic [XLEN-1:0]   i_s3_opr_b;
    logic [OP_W-1:0]   i_s3_uop;
    logic [FU_W-1:0]   i_s3_fu;
    logic              i_s3_trap;
    logic [1:0]        i_s3_size;
    logic [31:0]       i_s3_instr;
    logic              i_s3_valid;
    logic              o_s3_busy;
    logic [4:0]        o_fwd_rd;
    logic [XLEN-1:0]   o_fwd_wdata;
    logic              o_fwd_load;
    logic              o_fwd_csr;
    logic              o_dmem_req;
    logic              o_dmem_wen;
    logic [3:0]        o_dmem_strb;
    logic [XLEN-1:0]   o_dmem_wdata;
    logic [XLEN-1:0]   o_dmem_addr;
    logic              i_dmem_gnt;
    logic [4:0]        o_s4_rd;
    logic [XLEN-1:0]   o_s4_opr_a;
    logic [XLEN-1:0]   o_s4_opr_b;
    logic [OP_W-1:0]   o_s4_uop;
    logic [FU_W-1:0]   o_s4_fu;
    logic              o_s4_trap;
    logic [1:0]        o_s4_size;
    logic [31:0]       o_s4_instr;
    logic              o_s4_valid;
    logic              i_s4_busy;

    logic [116:0]      exp_q[$];                   // Expected stage-4 words
    logic [116:0]      cur_s4;                     // Entry under check
    logic              chk_s4;                     // Compare next edge
    logic [116:0]      s4_vec;
    logic [68:0]       dm_vec;
    logic [68:0]       dm_exp;                     // wen, strb, wdata, addr
    logic              dm_ok;                      // Request allowed now
    logic              granted;                    // Current instr got its grant
    string             test_name;
    int                err_cnt;
    int                n_issued;
    int                n_checked;

    frv_pipeline_memory UUT (.*);

    assign s4_vec = {o_s4_rd, o_s4_uop, o_s4_fu, o_s4_trap, o_s4_size,
                     o_s4_instr, o_s4_opr_a, o_s4_opr_b};
    assign dm_vec = {o_dmem_wen, o_dmem_strb, o_dmem_wdata, o_dmem_addr};

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    // ----------------------------
    // Reporting
    // ----------------------------
    task automatic log_mismatch(input string what, input logic [127:0] exp_v,
                                input logic [127:0] act_v);
        err_cnt++;
        $display("error %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    endtask

    task automatic log_failure(input string txt);
        err_cnt++;
        $display("%s: %s", test_name, txt);
    endtask

    // ----------------------------
    // Scoreboard and grant tracking
    // ----------------------------
    always @(posedge g_clk) begin
        chk_s4 <= 1'b0;
        if (!g_resetn) begin
            granted <= 1'b0;
        end else begin
            if (i_s3_valid && !o_s3_busy) begin     // Accepted this edge
                granted <= 1'b0;
                if (exp_q.size() > 0) begin
                    cur_s4 <= exp_q.pop_front();
                    chk_s4 <= 1'b1;
                    n_checked++;
                end else begin
                    log_failure("instruction accepted with no model entry");
                end
            end else if (o_dmem_req && i_dmem_gnt) begin
                granted <= 1'b1;
            end
        end
    end

    // ----------------------------
    // Assertions
    // ----------------------------
    a_s4_payload: assert property (@(posedge g_clk) disable iff (!g_resetn)
        chk_s4 |-> (o_s4_valid && s4_vec == cur_s4))
        else log_mismatch("s4", {10'd0, 1'b1, $sampled(cur_s4)},
                          {10'd0, $sampled(o_s4_valid), $sampled(s4_vec)});

    a_dmem_fields: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_dmem_req |-> (dm_ok && dm_vec == dm_exp))
        else log_mismatch("dmem", {59'd0, $sampled(dm_exp)}, {59'd0, $sampled(dm_vec)});

    a_req_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_dmem_req && !i_dmem_gnt) |=>
            (o_dmem_req && $stable(dm_vec) && $past(o_s3_busy)))
        else log_failure("request dropped or changed before its grant");

    a_one_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_dmem_req |-> !granted)
        else log_failure("second request for an already granted access");

    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (i_hold_lsu_req && !$past(o_dmem_req && !i_dmem_gnt)) |-> !o_dmem_req)
        else log_failure("request raised while held off");

    a_s4_stall: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (i_s4_busy && o_s4_valid && !i_flush) |=> $stable(s4_vec))
        else log_failure("stage-4 outputs moved while stage 4 was busy");

    a_s3_stall: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (i_s4_busy && o_s4_valid) |-> o_s3_busy)
        else log_failure("stage 3 not stalled by stage-4 back-pressure");

    a_flush: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_flush |=> !o_s4_valid)
        else log_failure("flush did not clear stage-4 valid");

    a_reset: assert property (@(posedge g_clk)
        $rose(g_resetn) |-> (!o_s4_valid && !o_dmem_req && !o_s3_busy))
        else log_failure("outputs not clear after reset");

    a_fwd: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_fwd_rd == i_s3_rd && o_fwd_wdata == i_s3_opr_a &&
         o_fwd_load == (i_s3_fu[P_FU_LSU] && i_s3_uop[LSU_LOAD]) &&
         o_fwd_csr == i_s3_fu[P_FU_CSR]))
        else log_failure("forwarding outputs do not follow stage 3");

    // ----------------------------
    // Stimulus
    // ----------------------------
    task automatic idle();
        i_s3_rd        = '0;
        i_s3_opr_a     = '0;
        i_s3_opr_b     = '0;
        i_s3_uop       = '0;
        i_s3_fu        = '0;
        i_s3_trap      = 1'b0;
        i_s3_size      = 2'b00;                   // Empty slot
        i_s3_instr     = '0;
        i_s3_valid     = 1'b0;
        i_dmem_gnt     = 1'b0;
        i_hold_lsu_req = 1'b0;
        i_s4_busy      = 1'b0;
        dm_ok          = 1'b0;
    endtask

    // Expected values come from the stage rules, then the slot is held till taken
    task automatic issue(input string name, input logic [FU_W-1:0] fu,
                         input logic [OP_W-1:0] uop, input logic [31:0] a,
                         input logic [31:0] b, input int hold_cyc, input int busy_cyc);
        logic        is_lsu;
        logic        mis;
        logic [1:0]  wid;
        logic [3:0]  strb;
        logic [31:0] lanes;
        logic [4:0]  rd;
        logic [31:0] instr;
        int          delay;
        int          waited;
        rd     = 5'($urandom);
        instr  = $urandom;
        is_lsu = fu[P_FU_LSU];
        wid    = uop[2:1];
        mis    = is_lsu && ((wid == LSU_HALF && a[0]) ||
                            (wid == LSU_WORD && a[1:0] != 2'b00));
        case (wid)
            LSU_BYTE: strb = 4'(1 << a[1:0]);      // One lane per offset
            LSU_HALF: strb = a[1] ? 4'b1100 : 4'b0011;
            LSU_WORD: strb = 4'b1111;
            default:  strb = 4'b0000;
        endcase
        case (wid)
            LSU_BYTE: lanes = {4{b[7:0]}};
            LSU_HALF: lanes = {2{b[15:0]}};
            default:  lanes = b;
        endcase
        exp_q.push_back({mis ? (uop[LSU_LOAD] ? TRAP_LDALIGN : TRAP_STALIGN) : rd,
                         uop, fu, mis, 2'b10, instr,
                         is_lsu ? {28'd0, strb} : a, is_lsu ? a : b});
        @(negedge g_clk);
        test_name      = name;
        n_issued++;
        i_s3_rd        = rd;
        i_s3_opr_a     = a;
        i_s3_opr_b     = b;
        i_s3_uop       = uop;
        i_s3_fu        = fu;
        i_s3_size      = 2'b10;
        i_s3_instr     = instr;
        i_s3_valid     = 1'b1;
        dm_ok          = is_lsu && !mis;
        dm_exp         = {uop[LSU_STORE], strb, lanes, a[31:2], 2'b00};
        delay          = $urandom % 4;             // Grant delay 0 to 3
        waited         = 0;
        i_hold_lsu_req = (hold_cyc > 0);
        i_s4_busy      = (busy_cyc > 0);
        forever begin
            i_dmem_gnt = dm_ok && !granted && !i_hold_lsu_req && (waited >= delay);
            @(posedge g_clk);
            if (!o_s3_busy) break;                 // Taken on this edge
            @(negedge g_clk);
            if (!i_hold_lsu_req) waited++;
            hold_cyc--;
            busy_cyc--;
            i_hold_lsu_req = (hold_cyc > 0);
            i_s4_busy      = (busy_cyc > 0);
        end
        @(negedge g_clk);
        idle();
    endtask

    task automatic mem_op(input string name, input logic st, input logic [1:0] wid,
                          input logic [31:0] addr, input int hold_cyc, input int busy_cyc);
        issue(name, 6'(1 << P_FU_LSU), {2'b00, st, !st, wid, 1'b0},
              addr, $urandom, hold_cyc, busy_cyc);
    endtask

    initial begin
        int          k;
        logic [31:0] base;
        void'($urandom(32'h163b_311b));
        err_cnt   = 0;
        n_issued  = 0;
        n_checked = 0;
        test_name = "reset";
        g_resetn  = 1'b0;
        i_flush   = 1'b0;
        idle();
        repeat (2) @(negedge g_clk);
        g_resetn = 1'b1;
        repeat (2) @(negedge g_clk);

        issue("alu", 6'(1 << P_FU_ALU), 7'h15, $urandom, $urandom, 0, 0);
        issue("csr", 6'(1 << P_FU_CSR), 7'h02, $urandom, $urandom, 0, 0);
        for (k = 0; k < 4; k++) begin
            base = {$urandom} & 32'hffff_fffc;
            mem_op("word_store", 1'b1, LSU_WORD, base, 0, 0);
        end
        base = {$urandom} & 32'hffff_fffc;
        for (k = 0; k < 4; k++) begin
            mem_op("byte_store", 1'b1, LSU_BYTE, base + 32'(k), 0, 0);
        end
        mem_op("half_store", 1'b1, LSU_HALF, base, 0, 0);
        mem_op("half_store", 1'b1, LSU_HALF, base + 32'd2, 0, 0);
        mem_op("byte_load", 1'b0, LSU_BYTE, base + 32'd3, 0, 0);
        mem_op("half_load", 1'b0, LSU_HALF, base + 32'd2, 0, 0);
        mem_op("mis_half_load", 1'b0, LSU_HALF, base + 32'd1, 0, 0);
        mem_op("mis_half_store", 1'b1, LSU_HALF, base + 32'd3, 0, 0);
        mem_op("mis_word_load", 1'b0, LSU_WORD, base + 32'd2, 0, 0);
        mem_op("mis_word_store", 1'b1, LSU_WORD, base + 32'd1, 0, 0);
        mem_op("hold_req", 1'b1, LSU_WORD, base, 3, 0);
        mem_op("s4_busy", 1'b1, LSU_HALF, base + 32'd2, 0, 5);
        issue("flush", 6'(1 << P_FU_ALU), 7'h09, $urandom, $urandom, 0, 0);
        i_flush = 1'b1;                            // Kill the ALU result in stage 4
        @(negedge g_clk);
        i_flush = 1'b0;
        for (k = 0; k < 16; k++) begin
            if ($urandom % 3 == 0) begin
                issue("random_alu", 6'(1 << P_FU_ALU), 7'($urandom), $urandom, $urandom, 0, 0);
            end else begin
                mem_op("random_mem", 1'($urandom), 2'($urandom_range(3, 1)), $urandom, 0, 0);
            end
        end

        test_name = "reset_again";
        g_resetn  = 1'b0;
        repeat (2) @(negedge g_clk);
        g_resetn = 1'b1;
        repeat (2) @(negedge g_clk);

        if (exp_q.size() != 0 || n_checked != n_issued) begin
            log_failure("some instructions never reached stage 4");
        end
        $display("issued %0d checked %0d errors %0d", n_issued, n_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Budget of 8 cycles per instruction plus setup
    initial begin
        repeat (N_INSTR * 8 + 50) @(posedge g_clk);
        $display("timeout: run did not finish within the cycle budget");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/frv_pkg.sv
hw/frv_lsu_if.sv
hw/frv_lsu.sv
hw/frv_pipeline_register.sv
hw/frv_pipeline_memory.sv
dv/frv_mem_tb.sv

//--- Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = frv_mem_tb
FLIST  = list.f
OBJDIR = obj_dir
BIN    = $(OBJDIR)/V$(TOP)
SRCS   = $(wildcard hw/*.sv dv/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# Status comes from the search for the pass line
run: $(BIN)
	./$(BIN) | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)
